// File: rv_decode.f
rv_decode_pkg.sv
decode_hs_if.sv
decode_alu.sv
decode_mem.sv
decode_branch.sv
skid_buffer.sv
decode_stage.sv
rv_decode_top.sv
decode_props.sv
tb_rv_decode.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rv_decode testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
TOP=tb_rv_decode

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

rm -rf "$BUILD_DIR"
rm -f "$LOG"

verilator --binary --assert --timing \
  --top-module "$TOP" \
  -f rv_decode.f \
  --Mdir "$BUILD_DIR" \
  -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

if [ ! -x "$BUILD_DIR/V$TOP" ]; then
  echo "simulation binary missing"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if ! grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
exit 0

// File: tb_rv_decode.sv
module tb_rv_decode
  import rv_decode_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_PKTS = 1500;
  localparam int WATCHDOG_CYCLES = N_PKTS * 20 + 200;

  logic        clk_core;
  logic        rst_core_n;
  logic        flush_i, flush_ack_o, valid_i, ready_o, fault_i, valid_o, ready_i;
  logic [31:0] pc_i, insn_i;
  issue_data_t issue_data_o;

  logic [31:0] lcg_state = 32'd76389;
  issue_data_t exp_q[$];
  int          sent = 0;
  logic        flush_prev = 1'b1;
  logic        run_checks = 1'b0;

  rv_decode_top rv_decode_top_inst (.*);

  bind rv_decode_top decode_props props_inst (.*);

  initial begin
    clk_core = 1'b0;
    forever #5 clk_core = ~clk_core;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic logic [31:0] gen_insn();
    logic [31:0] w;
    logic [4:0]  majors [10];
    int          pick;
    majors = '{5'b01100, 5'b00100, 5'b01101, 5'b00101, 5'b00000,
               5'b01000, 5'b11000, 5'b11011, 5'b11001, 5'b11100};
    w = next_rand();
    if (next_rand() % 3 == 0) return w;  // raw word.
    pick = next_rand() % 10;
    w[6:0] = {majors[pick], 2'b11};
    if (pick <= 1) w[31:25] = next_rand() % 2 ? 7'h20 : 7'h00;
    if (pick == 9) w = next_rand() % 2 ? 32'h0000_0073 : 32'h0010_0073;
    return w;
  endfunction

  // rv32i funct3 table, alt picks sub and sra.
  function automatic alu_op_e alu_op_for(logic [2:0] f3, logic alt);
    case (f3)
      3'd0: return alt ? SUB : ADD;
      3'd1: return SLL;
      3'd2: return SLT;
      3'd3: return SLTU;
      3'd4: return XOR;
      3'd5: return alt ? SRA : SRL;
      3'd6: return OR;
      default: return AND;
    endcase
  endfunction

  function automatic branch_cond_e branch_cond_for(logic [2:0] f3);
    case (f3)
      3'd0: return EQ;
      3'd1: return NE;
      3'd4: return LT;
      3'd5: return GE;
      3'd6: return LTU;
      default: return GEU;
    endcase
  endfunction

  // reference decode, straight from the rv32i encoding tables.
  function automatic issue_data_t model_decode(logic [31:0] pc, logic [31:0] insn,
                                               logic fault);
    issue_data_t e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        bad;
    e = '0;
    f3 = insn[14:12];
    f7 = insn[31:25];
    bad = 1'b0;
    e.pc = pc;
    e.fault = fault;
    e.common.rd = insn[11:7];
    e.common.rs1 = insn[19:15];
    e.common.rs2 = insn[24:20];
    case (insn[6:2])
      5'b01100: begin
        e.unit = EXEC_ALU;
        e.alu.op = alu_op_for(f3, f7[5]);
        bad = (f7 == 7'h20) ? !(f3 == 3'd0 || f3 == 3'd5) : (f7 != 7'h00);
      end
      5'b00100: begin
        e.unit = EXEC_ALU;
        e.alu.use_imm = 1'b1;
        e.common.imm = {{20{insn[31]}}, insn[31:20]};
        e.alu.op = alu_op_for(f3, (f3 == 3'd5) && f7[5]);
        if (f3 == 3'd1) bad = (f7 != 7'h00);
        if (f3 == 3'd5) bad = (f7 != 7'h00) && (f7 != 7'h20);
      end
      5'b01101, 5'b00101: begin
        e.unit = EXEC_ALU;
        e.alu.op = ADD;
        e.alu.use_imm = 1'b1;
        e.alu.use_pc = insn[5] ? 1'b0 : 1'b1;  // auipc adds the pc.
        e.common.imm = {insn[31:12], 12'h000};
        if (insn[5]) e.common.rs1 = 5'd0;
      end
      5'b00000: begin
        e.unit = EXEC_MEM;
        e.common.imm = {{20{insn[31]}}, insn[31:20]};
        e.mem.size = f3[1:0];
        e.mem.unsigned_load = f3[2];
        bad = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
      end
      5'b01000: begin
        e.unit = EXEC_MEM;
        e.common.imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
        e.mem.store = 1'b1;
        e.mem.size = f3[1:0];
        bad = (f3 > 3'd2);
      end
      5'b11000: begin
        e.unit = EXEC_BRANCH;
        e.branch.cond = branch_cond_for(f3);
        e.common.rd = 5'd0;
        e.common.imm = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
        bad = (f3 == 3'd2) || (f3 == 3'd3);
      end
      5'b11011: begin
        e.unit = EXEC_BRANCH;
        e.branch = '{cond: ALWAYS, is_jump: 1'b1, is_indirect: 1'b0};
        e.common.imm = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      end
      5'b11001: begin
        e.unit = EXEC_BRANCH;
        e.branch = '{cond: ALWAYS, is_jump: 1'b1, is_indirect: 1'b1};
        e.common.imm = {{20{insn[31]}}, insn[31:20]};
        bad = (f3 != 3'd0);
      end
      5'b11100: begin
        e.unit = EXEC_SYSTEM;
        e.common.imm = {{20{insn[31]}}, insn[31:20]};
        bad = (insn != 32'h0000_0073) && (insn != 32'h0010_0073);
      end
      default: bad = 1'b1;
    endcase
    if (bad || insn[1:0] != 2'b11 || fault) begin
      e.unit = EXEC_ALU;
      e.alu.illegal = 1'b1;
    end
    return e;
  endfunction

  task automatic report_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic compare_packet(issue_data_t got, issue_data_t exp);
    check_field("issue_data_o.unit", 32'(got.unit), 32'(exp.unit));
    check_field("issue_data_o.pc", got.pc, exp.pc);
    check_field("issue_data_o.alu.illegal", 32'(got.alu.illegal), 32'(exp.alu.illegal));
    check_field("issue_data_o.fault", 32'(got.fault), 32'(exp.fault));
    if (!exp.alu.illegal) begin
      check_field("issue_data_o.common.rd", 32'(got.common.rd), 32'(exp.common.rd));
      check_field("issue_data_o.common.rs1", 32'(got.common.rs1), 32'(exp.common.rs1));
      check_field("issue_data_o.common.rs2", 32'(got.common.rs2), 32'(exp.common.rs2));
      check_field("issue_data_o.common.imm", got.common.imm, exp.common.imm);
      case (exp.unit)
        EXEC_ALU: begin
          check_field("issue_data_o.alu.op", 32'(got.alu.op), 32'(exp.alu.op));
          check_field("issue_data_o.alu.use_imm", 32'(got.alu.use_imm), 32'(exp.alu.use_imm));
          check_field("issue_data_o.alu.use_pc", 32'(got.alu.use_pc), 32'(exp.alu.use_pc));
        end
        EXEC_MEM: begin
          check_field("issue_data_o.mem", 32'(got.mem), 32'(exp.mem));
        end
        EXEC_BRANCH: begin
          check_field("issue_data_o.branch", 32'(got.branch), 32'(exp.branch));
        end
        default: ;
      endcase
    end
  endtask

  // negedge view matches what the next rising edge will see.
  always @(negedge clk_core) begin
    if (run_checks) begin
      check_field("flush_ack_o", 32'(flush_ack_o), 32'(flush_prev));
      flush_prev = flush_i;
      if (flush_i) begin
        exp_q.delete();
      end else begin
        if (valid_o && ready_i) begin
          if (exp_q.size() == 0) begin
            $display("output transfer with no packet outstanding");
            report_failure();
          end else begin
            compare_packet(issue_data_o, exp_q.pop_front());
          end
        end
        if (valid_i && ready_o) exp_q.push_back(model_decode(pc_i, insn_i, fault_i));
      end
      if (valid_i && ready_o) sent++;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("watchdog expired before all packets came through the DUT");
    report_failure();
  end

  initial begin
    logic [31:0] pc_rand;
    rst_core_n <= 1'b0;
    flush_i <= 1'b0;
    valid_i <= 1'b0;
    ready_i <= 1'b0;
    fault_i <= 1'b0;
    pc_i <= '0;
    insn_i <= '0;
    repeat (3) @(posedge clk_core);
    rst_core_n <= 1'b1;
    @(negedge clk_core);
    check_field("valid_o", 32'(valid_o), 32'h0);
    check_field("ready_o", 32'(ready_o), 32'h1);
    check_field("flush_ack_o", 32'(flush_ack_o), 32'h1);
    run_checks = 1'b1;

    while (sent < N_PKTS) begin
      @(posedge clk_core);
      if (!valid_i || ready_o) begin // hold until taken.
        valid_i <= (next_rand() % 4 != 0);
        insn_i <= gen_insn();
        pc_rand = next_rand();
        pc_i <= {pc_rand[31:2], 2'b00};
        fault_i <= (next_rand() % 20 == 0);
      end
      flush_i <= (next_rand() % 60 == 0);
      ready_i <= (next_rand() % 3 != 0);
    end

    // drain, the last packet stays valid until taken.
    @(posedge clk_core);
    flush_i <= 1'b0;
    ready_i <= 1'b1;
    while (valid_i && !ready_o) @(posedge clk_core);
    valid_i <= 1'b0;
    do @(negedge clk_core); while (exp_q.size() != 0 || valid_o);

    if (rv_decode_top_inst.props_inst.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("bound handshake assertions failed during the run");
      report_failure();
    end
  end

endmodule

// File: decode_props.sv
module decode_props
  import rv_decode_pkg::*;
(
  input logic        clk_core,
  input logic        rst_core_n,
  input logic        flush_i,
  input logic        ready_o,
  input logic        valid_o,
  input logic        ready_i,
  input issue_data_t issue_data_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // a stalled output holds its packet.
  stable_when_stalled: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    valid_o && !ready_i && !flush_i |=> $stable(issue_data_o))
    else begin
      fail_count++;
      $error("issue data changed while stalled");
    end

  ready_when_empty: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    !valid_o |-> ready_o)
    else begin
      fail_count++;
      $error("ready low with empty buffers");
    end

  flush_clears_output: assert property (@(posedge clk_core) disable iff (!rst_core_n)
    flush_i |=> !valid_o)
    else begin
      fail_count++;
      $error("valid after flush");
    end

endmodule

// File: rv_decode_top.sv
module rv_decode_top
  import rv_decode_pkg::*;
#(
  parameter int DATA_W = $bits(issue_data_t)
) (
  input  logic        clk_core,
  input  logic        rst_core_n,
  input  logic        flush_i,
  output logic        flush_ack_o,
  input  logic        valid_i,
  output logic        ready_o,
  input  logic [31:0] pc_i,
  input  logic [31:0] insn_i,
  input  logic        fault_i,
  output logic        valid_o,
  input  logic        ready_i,
  output issue_data_t issue_data_o
);

  fetch_data_t fetch_data;

  assign fetch_data = '{pc: pc_i, insn: insn_i, fault: fault_i};

  decode_hs_if #(.DATA_W(DATA_W)) stage_hs ();

  decode_stage #(.DATA_W(DATA_W)) u_stage (
    .clk_core     (clk_core),
    .rst_core_n   (rst_core_n),
    .flush_i      (flush_i),
    .flush_ack_o  (flush_ack_o),
    .valid_i      (valid_i),
    .ready_o      (ready_o),
    .fetch_data_i (fetch_data),
    .out          (stage_hs.source)
  );

  skid_buffer #(.DATA_W(DATA_W)) u_skid (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .in         (stage_hs.sink),
    .data_o     (issue_data_o),
    .valid_o    (valid_o),
    .ready_i    (ready_i)
  );

endmodule

// File: decode_stage.sv
module decode_stage
  import rv_decode_pkg::*;
#(
  parameter int DATA_W = $bits(issue_data_t)
) (
  input  logic        clk_core,
  input  logic        rst_core_n,
  input  logic        flush_i,
  output logic        flush_ack_o,
  input  logic        valid_i,
  output logic        ready_o,
  input  fetch_data_t fetch_data_i,
  decode_hs_if.source out
);

  logic [31:0]  insn;
  logic         stall, illegal, trap;
  logic         illegal_alu, illegal_mem, illegal_branch;
  common_t      common, common_alu, common_mem, common_branch;
  alu_data_t    alu_data;
  mem_data_t    mem_data;
  branch_data_t branch_data;
  issue_data_t  issue_d;

  logic [DATA_W-1:0] data_q;
  logic              valid_q;

  assign insn    = fetch_data_i.insn;
  assign stall   = ~out.ready;
  assign ready_o = out.ready;

  assign common = '{rd: insn[11:7], rs1: insn[19:15], rs2: insn[24:20], imm: '0};

  decode_alu u_alu (
    .insn_i     (insn),
    .common_i   (common),
    .alu_data_o (alu_data),
    .common_o   (common_alu),
    .illegal_o  (illegal_alu)
  );

  decode_mem u_mem (
    .insn_i     (insn),
    .common_i   (common),
    .mem_data_o (mem_data),
    .common_o   (common_mem),
    .illegal_o  (illegal_mem)
  );

  decode_branch u_branch (
    .insn_i        (insn),
    .common_i      (common),
    .branch_data_o (branch_data),
    .common_o      (common_branch),
    .illegal_o     (illegal_branch)
  );

  always_comb begin
    issue_d = '{pc: fetch_data_i.pc, unit: EXEC_ALU, common: common, alu: alu_data,
                mem: mem_data, branch: branch_data, fault: fetch_data_i.fault};
    illegal = 1'b0;

    case (rv_major_e'(insn[6:2]))
      OP, OP_IMM, LUI, AUIPC: begin
        illegal = illegal_alu;
        issue_d.common = common_alu;
      end
      LOAD, STORE: begin
        illegal = illegal_mem;
        issue_d.unit = EXEC_MEM;
        issue_d.common = common_mem;
      end
      BRANCH, JAL, JALR: begin
        illegal = illegal_branch;
        issue_d.unit = EXEC_BRANCH;
        issue_d.common = common_branch;
      end
      SYSTEM: begin
        // only ecall and ebreak are supported.
        illegal = !(insn inside {INSN_ECALL, INSN_EBREAK});
        issue_d.unit = EXEC_SYSTEM;
        issue_d.common.imm = imm_i(insn);
      end
      default: illegal = 1'b1;
    endcase

    // compressed encodings trap as well.
    trap = illegal | (insn[1:0] != 2'b11) | fetch_data_i.fault;

    issue_d.alu.illegal = trap;
    if (trap) issue_d.unit = EXEC_ALU;  // commit handles the exception.
  end

  always_ff @(posedge clk_core) begin
    if (!stall) data_q <= issue_d;
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) flush_ack_o <= 1'b1;
    else flush_ack_o <= flush_i;
  end

  assign out.valid = valid_q;
  assign out.data  = data_q;
  assign out.flush = flush_i;

endmodule

// File: skid_buffer.sv
module skid_buffer #(
  parameter int DATA_W = 8
) (
  input  logic              clk_core,
  input  logic              rst_core_n,
  decode_hs_if.sink         in,
  output logic [DATA_W-1:0] data_o,
  output logic              valid_o,
  input  logic              ready_i
);

  logic [DATA_W-1:0] main_q, skid_q;
  logic              main_valid_q, skid_valid_q;
  logic              push, pop;

  assign in.ready = ~skid_valid_q;  // full only when both entries hold data.
  assign push     = in.valid & in.ready;
  assign pop      = main_valid_q & ready_i;

  assign data_o  = main_q;
  assign valid_o = main_valid_q;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (in.flush) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (pop && !push) begin
      main_valid_q <= skid_valid_q;
      skid_valid_q <= 1'b0;
    end else if (push && !pop) begin
      main_valid_q <= 1'b1;
      skid_valid_q <= main_valid_q;
    end
  end

  always_ff @(posedge clk_core) begin
    if (pop && !push) begin
      main_q <= skid_q;
    end else if (push) begin
      // pop and push together keep the skid empty.
      if (!main_valid_q || pop) main_q <= in.data;
      else skid_q <= in.data;
    end
  end

endmodule

// File: decode_branch.sv
module decode_branch
  import rv_decode_pkg::*;
(
  input  logic [31:0]  insn_i,
  input  common_t      common_i,
  output branch_data_t branch_data_o,
  output common_t      common_o,
  output logic         illegal_o
);

  logic [2:0] funct3;

  assign funct3 = insn_i[14:12];

  always_comb begin
    common_o      = common_i;
    branch_data_o = '{cond: ALWAYS, is_jump: 1'b1, is_indirect: 1'b0};
    illegal_o     = 1'b0;

    case (insn_i[3:2])
      2'b00: begin // conditional branch.
        branch_data_o.cond    = branch_cond_e'(funct3);
        branch_data_o.is_jump = 1'b0;
        illegal_o    = (funct3[2:1] == 2'b01);
        common_o.imm = imm_b(insn_i);
        common_o.rd  = '0;  // no link register.
      end
      2'b01: begin // jalr.
        branch_data_o.is_indirect = 1'b1;
        illegal_o    = (funct3 != 3'd0);
        common_o.imm = imm_i(insn_i);
      end
      default: begin
        common_o.imm = imm_j(insn_i);
      end
    endcase
  end

endmodule

// File: decode_mem.sv
module decode_mem
  import rv_decode_pkg::*;
(
  input  logic [31:0] insn_i,
  input  common_t     common_i,
  output mem_data_t   mem_data_o,
  output common_t     common_o,
  output logic        illegal_o
);

  logic [2:0] funct3;
  logic       is_store;

  assign funct3   = insn_i[14:12];
  assign is_store = insn_i[5];  // store major differs from load only here.

  always_comb begin
    common_o = common_i;

    mem_data_o.store         = is_store;
    mem_data_o.size          = funct3[1:0];
    mem_data_o.unsigned_load = funct3[2] & ~is_store;

    if (is_store) begin
      // sb, sh, sw only.
      common_o.imm = imm_s(insn_i);
      illegal_o    = funct3[2] | (funct3[1:0] == 2'b11);
    end else begin
      // lb, lh, lw, lbu, lhu.
      common_o.imm = imm_i(insn_i);
      illegal_o    = (funct3[1:0] == 2'b11) | (funct3 == 3'd6);
    end
  end

endmodule

// File: decode_alu.sv
module decode_alu
  import rv_decode_pkg::*;
(
  input  logic [31:0] insn_i,
  input  common_t     common_i,
  output alu_data_t   alu_data_o,
  output common_t     common_o,
  output logic        illegal_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  always_comb begin
    alu_data_o = '{op: ADD, use_imm: 1'b0, use_pc: 1'b0, illegal: 1'b0};
    common_o   = common_i;
    illegal_o  = 1'b0;

    // {bit 5, bit 2} tells the four alu majors apart.
    case ({insn_i[5], insn_i[2]})
      2'b10: begin // op.
        alu_data_o.op = alu_op_e'({funct7[5], funct3});
        if (funct7 == 7'h20) illegal_o = !(funct3 inside {3'd0, 3'd5});
        else illegal_o = (funct7 != 7'h00);
      end
      2'b00: begin // op-imm.
        alu_data_o.use_imm = 1'b1;
        common_o.imm = imm_i(insn_i);
        alu_data_o.op = alu_op_e'({(funct3 == 3'd5) && funct7[5], funct3});
        if (funct3 == 3'd1) illegal_o = (funct7 != 7'h00);
        else if (funct3 == 3'd5) illegal_o = (funct7 != 7'h00) && (funct7 != 7'h20);
      end
      2'b11: begin
        alu_data_o.use_imm = 1'b1;
        common_o.imm = imm_u(insn_i);
        common_o.rs1 = '0;  // lui adds to x0.
      end
      default: begin
        alu_data_o.use_imm = 1'b1;
        alu_data_o.use_pc  = 1'b1;
        common_o.imm = imm_u(insn_i);
      end
    endcase
  end

endmodule

// File: decode_hs_if.sv
interface decode_hs_if #(
  parameter int DATA_W = 8
);

  logic              valid;
  logic              ready;
  logic              flush;
  logic [DATA_W-1:0] data;

  modport source (
    output valid,
    output data,
    output flush,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  flush,
    output ready
  );

endinterface

// File: rv_decode_pkg.sv
package rv_decode_pkg;

  // major opcode, instruction bits 6:2.
  typedef enum logic [4:0] {
    LOAD   = 5'b00000,
    OP_IMM = 5'b00100,
    AUIPC  = 5'b00101,
    STORE  = 5'b01000,
    OP     = 5'b01100,
    LUI    = 5'b01101,
    BRANCH = 5'b11000,
    JALR   = 5'b11001,
    JAL    = 5'b11011,
    SYSTEM = 5'b11100
  } rv_major_e;

  localparam logic [31:0] INSN_ECALL  = 32'h0000_0073;
  localparam logic [31:0] INSN_EBREAK = 32'h0010_0073;

  typedef enum logic [1:0] {
    EXEC_ALU,
    EXEC_MEM,
    EXEC_BRANCH,
    EXEC_SYSTEM
  } exec_unit_e;

  // encoded as {funct7[5], funct3}.
  typedef enum logic [3:0] {
    ADD  = 4'b0000,
    SLL  = 4'b0001,
    SLT  = 4'b0010,
    SLTU = 4'b0011,
    XOR  = 4'b0100,
    SRL  = 4'b0101,
    OR   = 4'b0110,
    AND  = 4'b0111,
    SUB  = 4'b1000,
    SRA  = 4'b1101
  } alu_op_e;

  // branch funct3 directly, ALWAYS sits in an unused slot.
  typedef enum logic [2:0] {
    EQ     = 3'd0,
    NE     = 3'd1,
    ALWAYS = 3'd2,
    LT     = 3'd4,
    GE     = 3'd5,
    LTU    = 3'd6,
    GEU    = 3'd7
  } branch_cond_e;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] insn;
    logic        fault;
  } fetch_data_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
  } common_t;

  typedef struct packed {
    alu_op_e op;
    logic    use_imm;
    logic    use_pc;
    logic    illegal;
  } alu_data_t;

  typedef struct packed {
    logic       store;
    logic [1:0] size;
    logic       unsigned_load;
  } mem_data_t;

  typedef struct packed {
    branch_cond_e cond;
    logic         is_jump;
    logic         is_indirect;
  } branch_data_t;

  typedef struct packed {
    logic [31:0]  pc;
    exec_unit_e   unit;
    common_t      common;
    alu_data_t    alu;
    mem_data_t    mem;
    branch_data_t branch;
    logic         fault;
  } issue_data_t;

  function automatic logic [31:0] imm_i(input logic [31:0] insn);
    return {{20{insn[31]}}, insn[31:20]};
  endfunction

  function automatic logic [31:0] imm_s(input logic [31:0] insn);
    return {{20{insn[31]}}, insn[31:25], insn[11:7]};
  endfunction

  function automatic logic [31:0] imm_b(input logic [31:0] insn);
    return {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] imm_u(input logic [31:0] insn);
    return {insn[31:12], 12'b0};
  endfunction

  function automatic logic [31:0] imm_j(input logic [31:0] insn);
    return {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  endfunction

endpackage
